// File: verilog/bsplit_pkg.sv
`default_nettype none

package bsplit_pkg;

  localparam int ID_W   = 4;
  localparam int ADDR_W = 32;
  localparam int LEN_W  = 8;
  localparam int REP_W  = 8;
  localparam int MB_W   = 5; // Holds max_beats up to 16.

  localparam int BYTES_PER_BEAT  = 4;
  localparam int MAX_BEATS_LIMIT = 16;
  localparam int QUEUE_DEPTH     = 4;

  localparam int APB_AW    = 8;
  localparam int APB_DW    = 32;
  localparam int ERR_CNT_W = 16;

  localparam logic [APB_AW-1:0] REG_MAX_BEATS = 8'h0;
  localparam logic [APB_AW-1:0] REG_ERR_COUNT = 8'h4;

  // Numeric order doubles as severity order when responses are merged.
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'd0,
    RESP_EXOKAY = 2'd1,
    RESP_SLVERR = 2'd2,
    RESP_DECERR = 2'd3
  } resp_e;

  typedef enum logic {
    SPLIT_IDLE  = 1'b0,
    SPLIT_ISSUE = 1'b1
  } split_state_e;

endpackage

`default_nettype wire

// File: verilog/cmd_if.sv
`timescale 1ns/10ps
`default_nettype none

// One command per slave burst, passed from the splitter to the merger.
interface cmd_if import bsplit_pkg::*; ();

  logic             valid;
  logic             ready;
  logic             split;      // Burst was cut into more than one piece.
  logic [REP_W-1:0] repeat_cnt; // Pieces minus one.
  logic [ID_W-1:0]  id;

  modport producer (output valid, output split, output repeat_cnt, output id, input ready);

  modport consumer (input valid, input split, input repeat_cnt, input id, output ready);

endinterface

`default_nettype wire

// File: verilog/aw_splitter.sv
`timescale 1ns/10ps
`default_nettype none

module aw_splitter import bsplit_pkg::*; (
  input  wire                ACLK,
  input  wire                ARESET,
  input  wire                s_awvalid,
  output logic               s_awready,
  input  wire  [ID_W-1:0]    s_awid,
  input  wire  [ADDR_W-1:0]  s_awaddr,
  input  wire  [LEN_W-1:0]   s_awlen,
  output logic               m_awvalid,
  input  wire                m_awready,
  output logic [ID_W-1:0]    m_awid,
  output logic [ADDR_W-1:0]  m_awaddr,
  output logic [LEN_W-1:0]   m_awlen,
  input  wire  [MB_W-1:0]    max_beats,
  cmd_if.producer            cmd
);

  split_state_e      state;
  logic [MB_W-1:0]   mb_q;
  logic [ID_W-1:0]   id_q;
  logic [ADDR_W-1:0] addr_q;
  logic [LEN_W:0]    remain_q;  // Beats not yet issued on the master side.
  logic [LEN_W:0]    beats;
  logic [LEN_W:0]    mb_ext;
  logic [LEN_W:0]    pieces;
  logic [LEN_W:0]    piece;
  logic              s_accept;
  logic              m_accept;

  // The piece count is needed in the acceptance cycle, as the command goes out with it.
  assign beats  = {1'b0, s_awlen} + 1'b1;
  assign mb_ext = (LEN_W+1)'(max_beats);
  assign pieces = (beats + mb_ext - 1'b1) / mb_ext;

  assign cmd.valid      = (state == SPLIT_IDLE) && s_awvalid;
  assign cmd.split      = (pieces > 1);
  assign cmd.repeat_cnt = REP_W'(pieces - 1'b1);
  assign cmd.id         = s_awid;

  assign s_awready = (state == SPLIT_IDLE) && cmd.ready;
  assign s_accept  = s_awvalid && s_awready;

  assign piece = (remain_q < (LEN_W+1)'(mb_q)) ? remain_q : (LEN_W+1)'(mb_q);

  assign m_awvalid = (state == SPLIT_ISSUE); // Straight from the state flop.
  assign m_awid    = id_q;
  assign m_awaddr  = addr_q;
  assign m_awlen   = LEN_W'(piece - 1'b1);
  assign m_accept  = m_awvalid && m_awready;

  always_ff @(posedge ACLK) begin
    if (ARESET) begin
      state <= SPLIT_IDLE;
    end else if (s_accept) begin
      state <= SPLIT_ISSUE;
    end else if (m_accept && (remain_q == piece)) begin
      state <= SPLIT_IDLE; // Last piece has gone out.
    end
  end

  always_ff @(posedge ACLK) begin
    if (s_accept) begin
      mb_q     <= max_beats;
      id_q     <= s_awid;
      addr_q   <= s_awaddr;
      remain_q <= beats;
    end else if (m_accept) begin
      remain_q <= remain_q - piece;
      addr_q   <= addr_q + ADDR_W'(piece * BYTES_PER_BEAT);
    end
  end

endmodule

`default_nettype wire

// File: verilog/cmd_queue.sv
`timescale 1ns/10ps
`default_nettype none

module cmd_queue import bsplit_pkg::*; (
  input wire      ACLK,
  input wire      ARESET,
  cmd_if.consumer wr,
  cmd_if.producer rd
);

  logic [$clog2(QUEUE_DEPTH)-1:0] wr_ptr;
  logic [$clog2(QUEUE_DEPTH)-1:0] rd_ptr;
  logic [$clog2(QUEUE_DEPTH):0]   count;
  logic                           split_mem [QUEUE_DEPTH];
  logic [REP_W-1:0]               rep_mem [QUEUE_DEPTH];
  logic [ID_W-1:0]                id_mem [QUEUE_DEPTH];
  logic                           push;
  logic                           pop;

  assign wr.ready = (count != QUEUE_DEPTH);
  assign push     = wr.valid && wr.ready;

  // The head entry stays put until popped, so the fields hold under back-pressure.
  assign rd.valid      = (count != 0);
  assign rd.split      = split_mem[rd_ptr];
  assign rd.repeat_cnt = rep_mem[rd_ptr];
  assign rd.id         = id_mem[rd_ptr];
  assign pop           = rd.valid && rd.ready;

  always_ff @(posedge ACLK) begin
    if (push) begin
      split_mem[wr_ptr] <= wr.split;
      rep_mem[wr_ptr]   <= wr.repeat_cnt;
      id_mem[wr_ptr]    <= wr.id;
    end
  end

  always_ff @(posedge ACLK) begin
    if (ARESET) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1; // Depth is a power of two.
      if (pop) rd_ptr <= rd_ptr + 1'b1;
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/b_merger.sv
`timescale 1ns/10ps
`default_nettype none

module b_merger import bsplit_pkg::*; (
  input  wire              ACLK,
  input  wire              ARESET,
  cmd_if.consumer          cmd,
  input  wire              m_bvalid,
  output logic             m_bready,
  input  var resp_e        m_bresp,
  output logic             s_bvalid,
  input  wire              s_bready,
  output logic [ID_W-1:0]  s_bid,
  output resp_e            s_bresp
);

  logic             first_q;   // Next master B is the first of its command.
  logic [REP_W-1:0] rep_q;
  logic [REP_W-1:0] rep_cur;
  resp_e            acc_q;
  resp_e            merged;
  logic             last;
  logic             pop_b;

  assign last = (!first_q && (rep_q == '0)) || !cmd.split;

  // Only the final response waits on the slave side.
  assign m_bready = m_bvalid && cmd.valid && (s_bready || !last);
  assign pop_b    = m_bvalid && m_bready;
  assign cmd.ready = pop_b && last;

  assign s_bvalid = m_bvalid && cmd.valid && last;
  assign s_bid    = cmd.id;
  assign s_bresp  = merged;

  always_comb begin
    if (!cmd.split) begin
      merged = m_bresp;
    end else if (first_q || (m_bresp > acc_q)) begin
      merged = m_bresp;
    end else begin
      merged = acc_q;
    end
  end

  assign rep_cur = first_q ? cmd.repeat_cnt : rep_q;

  always_ff @(posedge ACLK) begin
    if (ARESET) begin
      first_q <= 1'b1;
      rep_q   <= '0;
      acc_q   <= RESP_OKAY;
    end else if (pop_b) begin
      first_q <= last;
      rep_q   <= rep_cur - 1'b1;
      acc_q   <= merged;
    end
  end

endmodule

`default_nettype wire

// File: verilog/apb_regs.sv
`timescale 1ns/10ps
`default_nettype none

module apb_regs import bsplit_pkg::*; (
  input  wire                ACLK,
  input  wire                ARESET,
  input  wire                psel,
  input  wire                penable,
  input  wire                pwrite,
  input  wire  [APB_AW-1:0]  paddr,
  input  wire  [APB_DW-1:0]  pwdata,
  output logic [APB_DW-1:0]  prdata,
  output logic               pready,
  output logic               pslverr,
  output logic [MB_W-1:0]    max_beats,
  input  wire                resp_fire,
  input  wire                resp_is_err
);

  logic [ERR_CNT_W-1:0] err_count;
  logic                 access;
  logic                 addr_hit;
  logic                 wr_en;

  assign access   = psel && penable;
  assign addr_hit = (paddr == REG_MAX_BEATS) || (paddr == REG_ERR_COUNT);
  assign wr_en    = access && pwrite && addr_hit;

  assign pready  = 1'b1;
  assign pslverr = access && !addr_hit;

  always_comb begin
    case (paddr)
      REG_MAX_BEATS: prdata = APB_DW'(max_beats);
      REG_ERR_COUNT: prdata = APB_DW'(err_count);
      default:       prdata = '0;
    endcase
  end

  always_ff @(posedge ACLK) begin
    if (ARESET) begin
      max_beats <= MB_W'(MAX_BEATS_LIMIT);
      err_count <= '0;
    end else begin
      if (wr_en && (paddr == REG_MAX_BEATS)) begin
        // Zero or an oversize value falls back to the limit.
        if ((pwdata == '0) || (pwdata > MAX_BEATS_LIMIT)) max_beats <= MB_W'(MAX_BEATS_LIMIT);
        else max_beats <= pwdata[MB_W-1:0];
      end
      if (wr_en && (paddr == REG_ERR_COUNT)) begin
        err_count <= '0; // Clear wins over a same-cycle error.
      end else if (resp_fire && resp_is_err && (err_count != '1)) begin
        err_count <= err_count + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/bsplit_top.sv
`timescale 1ns/10ps
`default_nettype none

module bsplit_top import bsplit_pkg::*; (
  input  wire                ACLK,
  input  wire                ARESET,
  input  wire                s_awvalid,
  output logic               s_awready,
  input  wire  [ID_W-1:0]    s_awid,
  input  wire  [ADDR_W-1:0]  s_awaddr,
  input  wire  [LEN_W-1:0]   s_awlen,
  output logic               m_awvalid,
  input  wire                m_awready,
  output logic [ID_W-1:0]    m_awid,
  output logic [ADDR_W-1:0]  m_awaddr,
  output logic [LEN_W-1:0]   m_awlen,
  input  wire                m_bvalid,
  output logic               m_bready,
  input  var resp_e          m_bresp,
  output logic               s_bvalid,
  input  wire                s_bready,
  output logic [ID_W-1:0]    s_bid,
  output resp_e              s_bresp,
  input  wire                psel,
  input  wire                penable,
  input  wire                pwrite,
  input  wire  [APB_AW-1:0]  paddr,
  input  wire  [APB_DW-1:0]  pwdata,
  output logic [APB_DW-1:0]  prdata,
  output logic               pready,
  output logic               pslverr
);

  logic [MB_W-1:0] max_beats;
  logic            resp_fire;
  logic            resp_is_err;

  cmd_if split_cmd ();
  cmd_if merge_cmd ();

  // Any merged response above OKAY counts as an error.
  assign resp_fire   = s_bvalid && s_bready;
  assign resp_is_err = (s_bresp != RESP_OKAY);

  aw_splitter splitter_i (
    .ACLK, .ARESET, .s_awvalid, .s_awready, .s_awid, .s_awaddr, .s_awlen,
    .m_awvalid, .m_awready, .m_awid, .m_awaddr, .m_awlen, .max_beats, .cmd(split_cmd)
  );

  cmd_queue queue_i (.ACLK, .ARESET, .wr(split_cmd), .rd(merge_cmd));

  b_merger merger_i (
    .ACLK, .ARESET, .cmd(merge_cmd), .m_bvalid, .m_bready, .m_bresp,
    .s_bvalid, .s_bready, .s_bid, .s_bresp
  );

  apb_regs regs_i (
    .ACLK, .ARESET, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready,
    .pslverr, .max_beats, .resp_fire, .resp_is_err
  );

endmodule

`default_nettype wire

// File: tests/tb_bsplit.sv
`timescale 1ns/10ps
`default_nettype none

module tb_bsplit import bsplit_pkg::*; ();

  logic              ACLK;
  logic              ARESET;
  logic              s_awvalid, s_awready, m_awvalid, m_bready, s_bvalid;
  logic              m_awready = 1'b1;
  logic              m_bvalid  = 1'b0;
  logic              s_bready  = 1'b1;
  logic [ID_W-1:0]   s_awid, m_awid, s_bid;
  logic [ADDR_W-1:0] s_awaddr, m_awaddr;
  logic [LEN_W-1:0]  s_awlen, m_awlen;
  resp_e             m_bresp = RESP_OKAY;
  resp_e             s_bresp;
  logic              psel, penable, pwrite, pready, pslverr;
  logic [APB_AW-1:0] paddr;
  logic [APB_DW-1:0] pwdata, prdata;

  integer            seed = 32'h7965;
  int                errors, failed, tests, mb_count, b_issued, aw_rd, sb_rd, cyc;
  bit                stall_en;
  resp_e             bresp_q[$];   // Master B responses, returned in this order.
  logic [ADDR_W-1:0] aw_addr_q[$];
  logic [LEN_W-1:0]  aw_len_q[$];
  logic [ID_W-1:0]   aw_id_q[$], sb_id_q[$];
  resp_e             sb_resp_q[$];
  int                sb_at_q[$];   // Master B count when each slave B completed.

  bsplit_top dut_i (.*);

  initial begin
    ACLK = 1'b0;
    forever #50 ACLK = ~ACLK;
  end

  // Records every handshake on the master AW, master B and slave B channels.
  always @(posedge ACLK) begin
    if (m_awvalid && m_awready) begin
      aw_addr_q.push_back(m_awaddr);
      aw_len_q.push_back(m_awlen);
      aw_id_q.push_back(m_awid);
    end
    if (m_bvalid && m_bready) mb_count++;
    if (s_bvalid && s_bready) begin
      sb_id_q.push_back(s_bid);
      sb_resp_q.push_back(s_bresp);
      sb_at_q.push_back(mb_count);
    end
  end

  // Master model. One B per recorded AW, the next one only after the last was taken.
  always @(negedge ACLK) begin
    cyc++;
    s_bready  <= !stall_en || (cyc % 3 == 0);
    m_awready <= !stall_en || (cyc % 2 == 0); // AW back-pressure while stalls are on.
    if (mb_count == b_issued) begin
      if (aw_addr_q.size() > b_issued && bresp_q.size() > b_issued) begin
        m_bresp  <= bresp_q[b_issued];
        m_bvalid <= 1'b1;
        b_issued++;
      end else begin
        m_bvalid <= 1'b0;
      end
    end
  end

  task automatic check_word(input string name, input logic [ADDR_W-1:0] got,
                            input logic [ADDR_W-1:0] exp);
    if (got !== exp) begin
      $display("mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_id(input string name, input logic [ID_W-1:0] got,
                          input logic [ID_W-1:0] exp);
    if (got !== exp) begin
      $display("mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_resp(input string name, input resp_e got, input resp_e exp);
    if (got !== exp) begin
      $display("mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
      errors++;
    end
  endtask

  // A read compares PRDATA with data. Every access compares PSLVERR.
  task automatic apb_xfer(input logic wr, input logic [APB_AW-1:0] addr,
                          input logic [APB_DW-1:0] data, input logic exp_err);
    int t;
    t       = 0;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = data;
    @(negedge ACLK);
    penable = 1'b1;
    do begin
      @(posedge ACLK);
      t++;
    end while (!pready && t < 16);
    if (!pready) begin
      $display("APB access to 0x%h never completed", addr);
      errors++;
    end
    if (!wr) check_word("prdata", prdata, data);
    check_word("pslverr", ADDR_W'(pslverr), ADDR_W'(exp_err));
    @(negedge ACLK);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic send_aw(input logic [ID_W-1:0] id, input logic [ADDR_W-1:0] addr,
                         input logic [LEN_W-1:0] len);
    int t;
    t         = 0;
    s_awvalid = 1'b1;
    s_awid    = id;
    s_awaddr  = addr;
    s_awlen   = len;
    do begin
      @(posedge ACLK);
      t++;
    end while (!s_awready && t < 64);
    if (!s_awready) begin
      $display("slave AW with ID 0x%h was not accepted", id);
      errors++;
    end
    @(negedge ACLK);
    s_awvalid = 1'b0;
  endtask

  task automatic expect_slave_b(input logic [ID_W-1:0] id, input resp_e resp);
    int t;
    t = 0;
    while (sb_id_q.size() <= sb_rd && t < 300) begin
      @(negedge ACLK);
      t++;
    end
    if (sb_id_q.size() <= sb_rd) begin
      $display("no slave B response for ID 0x%h within %0d cycles", id, t);
      errors++;
    end else begin
      check_id("s_bid", sb_id_q[sb_rd], id);
      check_resp("s_bresp", sb_resp_q[sb_rd], resp);
      sb_rd++;
    end
  endtask

  // Each piece is the smaller of the remaining beats and mb.
  task automatic check_pieces(input logic [ID_W-1:0] id, input logic [ADDR_W-1:0] addr,
                              input int len, input int mb);
    int remain;
    int beats;
    logic [ADDR_W-1:0] a;
    remain = len + 1;
    a      = addr;
    while (remain > 0) begin
      beats = (remain < mb) ? remain : mb;
      if (aw_rd >= aw_addr_q.size()) begin
        $display("master AW piece at 0x%h for ID 0x%h is missing", a, id);
        errors++;
        return;
      end
      check_word("m_awaddr", aw_addr_q[aw_rd], a);
      check_word("m_awlen", ADDR_W'(aw_len_q[aw_rd]), ADDR_W'(beats - 1));
      check_id("m_awid", aw_id_q[aw_rd], id);
      aw_rd++;
      remain -= beats;
      a += ADDR_W'(beats * BYTES_PER_BEAT);
    end
  endtask

  task automatic end_test(input string name, input int errors_before);
    tests++;
    if (errors == errors_before) begin
      $display("test %s: passed", name);
    end else begin
      failed++;
      $display("test %s: failed with %0d errors", name, errors - errors_before);
    end
  endtask

  task automatic test_reg_defaults();
    int e0;
    e0 = errors;
    apb_xfer(1'b0, REG_MAX_BEATS, 32'd16, 1'b0);
    apb_xfer(1'b0, REG_ERR_COUNT, 32'd0, 1'b0);
    end_test("register defaults", e0);
  endtask

  task automatic test_split_merge();
    int e0;
    int base;
    e0   = errors;
    base = mb_count;
    bresp_q.push_back(RESP_OKAY);
    bresp_q.push_back(RESP_SLVERR);
    bresp_q.push_back(RESP_OKAY);
    send_aw(4'h5, 32'h0000_1000, 8'd40);
    expect_slave_b(4'h5, RESP_SLVERR); // Worst of the three.
    check_word("master B count at slave B", ADDR_W'(sb_at_q[sb_rd - 1]), ADDR_W'(base + 3));
    check_pieces(4'h5, 32'h0000_1000, 40, 16);
    bresp_q.push_back(RESP_EXOKAY);
    send_aw(4'h2, 32'h0000_2000, 8'd3);
    expect_slave_b(4'h2, RESP_EXOKAY);
    check_pieces(4'h2, 32'h0000_2000, 3, 16);
    end_test("split and merge", e0);
  endtask

  task automatic test_max_beats();
    int e0;
    e0 = errors;
    apb_xfer(1'b1, REG_MAX_BEATS, 32'd4, 1'b0);
    apb_xfer(1'b0, REG_MAX_BEATS, 32'd4, 1'b0);
    repeat (3) bresp_q.push_back(RESP_OKAY);
    send_aw(4'h9, 32'h0000_3000, 8'd9);
    expect_slave_b(4'h9, RESP_OKAY);
    check_pieces(4'h9, 32'h0000_3000, 9, 4);
    apb_xfer(1'b1, REG_MAX_BEATS, 32'd0, 1'b0);
    apb_xfer(1'b0, REG_MAX_BEATS, 32'd16, 1'b0);
    apb_xfer(1'b1, 8'h8, 32'd0, 1'b1);
    end_test("max_beats register", e0);
  endtask

  task automatic test_err_count();
    int e0;
    int len;
    int n;
    int exp_err;
    resp_e r;
    resp_e worst;
    e0      = errors;
    exp_err = 0;
    apb_xfer(1'b1, REG_ERR_COUNT, 32'd0, 1'b0);
    for (int i = 0; i < 8; i++) begin
      len   = $unsigned($random(seed)) % 48;
      n     = (len + 16) / 16; // Pieces at max_beats 16.
      worst = RESP_OKAY;
      for (int j = 0; j < n; j++) begin
        r = resp_e'(2'($random(seed)));
        if (r > worst) worst = r;
        bresp_q.push_back(r);
      end
      if (worst != RESP_OKAY) exp_err++;
      send_aw(ID_W'(i), 32'h0000_4000 + ADDR_W'(i * 256), LEN_W'(len));
      expect_slave_b(ID_W'(i), worst);
      check_pieces(ID_W'(i), 32'h0000_4000 + ADDR_W'(i * 256), len, 16);
    end
    apb_xfer(1'b0, REG_ERR_COUNT, APB_DW'(exp_err), 1'b0);
    apb_xfer(1'b1, REG_ERR_COUNT, 32'd1, 1'b0);
    apb_xfer(1'b0, REG_ERR_COUNT, 32'd0, 1'b0);
    end_test("error counter", e0);
  endtask

  task automatic test_backpressure();
    int e0;
    e0       = errors;
    stall_en = 1'b1;
    send_aw(4'h1, 32'h0000_5000, 8'd20); // Two pieces.
    send_aw(4'h2, 32'h0000_6000, 8'd5);
    send_aw(4'h3, 32'h0000_7000, 8'd35); // Three pieces.
    bresp_q.push_back(RESP_EXOKAY);
    bresp_q.push_back(RESP_OKAY);
    bresp_q.push_back(RESP_DECERR);
    bresp_q.push_back(RESP_OKAY);
    bresp_q.push_back(RESP_SLVERR);
    bresp_q.push_back(RESP_EXOKAY);
    expect_slave_b(4'h1, RESP_EXOKAY);
    expect_slave_b(4'h2, RESP_DECERR);
    expect_slave_b(4'h3, RESP_SLVERR);
    stall_en = 1'b0;
    check_pieces(4'h1, 32'h0000_5000, 20, 16);
    check_pieces(4'h2, 32'h0000_6000, 5, 16);
    check_pieces(4'h3, 32'h0000_7000, 35, 16);
    check_word("slave B count", ADDR_W'(sb_id_q.size()), ADDR_W'(sb_rd));
    check_word("master AW count", ADDR_W'(aw_addr_q.size()), ADDR_W'(aw_rd));
    end_test("queued bursts with back-pressure", e0);
  endtask

  initial begin
    ARESET    = 1'b1;
    s_awvalid = 1'b0;
    s_awid    = '0;
    s_awaddr  = '0;
    s_awlen   = '0;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    paddr     = '0;
    pwdata    = '0;
    repeat (3) @(posedge ACLK);
    @(negedge ACLK);
    ARESET = 1'b0;
    test_reg_defaults();
    test_split_merge();
    test_max_beats();
    test_err_count();
    test_backpressure();
    $display("%0d tests, %0d failed, %0d errors", tests, failed, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: filelist.f
verilog/bsplit_pkg.sv
verilog/cmd_if.sv
verilog/aw_splitter.sv
verilog/cmd_queue.sv
verilog/b_merger.sv
verilog/apb_regs.sv
verilog/bsplit_top.sv
tests/tb_bsplit.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the burst splitter testbench with Verilator and runs it.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_bsplit -f filelist.f -o sim_bsplit
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/sim_bsplit)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "TEST RESULT: PASS" <<< "$output"; then
  exit 0
fi
exit 1
